// File: verilog.f
+incdir+rtl
rtl/axi_pkg.sv
rtl/mem_pkg.sv
rtl/axi_bus_if.sv
rtl/fifo_v3.sv
rtl/axi_fifo.sv
rtl/axi_mem_sbr.sv
rtl/axi_mem_sys.sv
test/tb_axi_mem_sys.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the AXI memory subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f verilog.f \
  --top-module tb_axi_mem_sys \
  -o sim_tb

# Exit status is nonzero when the testbench stops with $fatal
./obj_dir/sim_tb

// File: test/tb_axi_mem_sys.sv
// ==========================================================================
// AXI memory subsystem testbench
// Single-beat writes and reads from an LFSR, random response stalls and
// a reference memory, with assertions checking every response
// ==========================================================================
`timescale 1ns/100ps
`default_nettype none

`include "axi_defines.svh"

module tb_axi_mem_sys;

  import axi_pkg::*;

  localparam int TIMEOUT     = 2000;
  localparam int STALL_LIMIT = 16;
  localparam int OFFS        = $clog2(`AXI_DATA_WIDTH / 8);

  typedef struct {
    id_t   id;
    resp_e resp;
    data_t data;
    int    word;
  } exp_t;

  logic  clk_i = 1'b0;
  logic  rst_n_i;
  logic  aw_valid_i, w_valid_i, ar_valid_i, b_ready_i, r_ready_i;
  logic  aw_ready_o, w_ready_o, ar_ready_o, b_valid_o, r_valid_o;
  id_t   aw_id_i, ar_id_i, b_id_o, r_id_o;
  addr_t aw_addr_i, ar_addr_i;
  data_t w_data_i, r_data_o;
  strb_t w_strb_i;
  resp_e b_resp_o, r_resp_o;

  data_t       ref_mem [int];
  exp_t        exp_b [$];
  exp_t        exp_r [$];
  logic [31:0] stim_lfsr  = 32'h8552;
  logic [31:0] stall_lfsr = 32'h8552;
  bit          hold_resp;
  bit          req_seen;
  bit          stuck;
  addr_t       addr;
  int          n;

  always #4 clk_i = ~clk_i;

  axi_mem_sys dut (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .aw_valid_i (aw_valid_i),
    .aw_ready_o (aw_ready_o),
    .aw_id_i    (aw_id_i),
    .aw_addr_i  (aw_addr_i),
    .w_valid_i  (w_valid_i),
    .w_ready_o  (w_ready_o),
    .w_data_i   (w_data_i),
    .w_strb_i   (w_strb_i),
    .b_valid_o  (b_valid_o),
    .b_ready_i  (b_ready_i),
    .b_id_o     (b_id_o),
    .b_resp_o   (b_resp_o),
    .ar_valid_i (ar_valid_i),
    .ar_ready_o (ar_ready_o),
    .ar_id_i    (ar_id_i),
    .ar_addr_i  (ar_addr_i),
    .r_valid_o  (r_valid_o),
    .r_ready_i  (r_ready_i),
    .r_id_o     (r_id_o),
    .r_data_o   (r_data_o),
    .r_resp_o   (r_resp_o)
  );

  task automatic report_error(input string msg);
    $display("FAIL @ %0t: %s", $time, msg);
    $display("Result: FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic timeout_fail(input string what);
    $display("Timeout while waiting for %s", what);
    $display("Result: FAILED");
    $fatal(1, "stopped on timeout");
  endtask

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int count);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < count; i++) begin
      stim_lfsr = lfsr_step(stim_lfsr);
      v = {v[30:0], stim_lfsr[0]};
    end
    return v;
  endfunction

  // About one address in eight lands far beyond the memory
  function automatic addr_t rand_addr();
    logic [31:0] r;
    if (rand_bits(3) == 0) begin
      r = rand_bits(15);
      return {1'b1, r[14:0]};
    end
    r = rand_bits(10);
    return {6'b0, r[9:0]};
  endfunction

  function automatic int addr_word(input addr_t a);
    return int'(a[`AXI_ADDR_WIDTH-1:OFFS]);
  endfunction

  function automatic bit word_busy(input int word);
    foreach (exp_b[i]) begin
      if (exp_b[i].word == word) return 1'b1;
    end
    foreach (exp_r[i]) begin
      if (exp_r[i].word == word) return 1'b1;
    end
    return 1'b0;
  endfunction

  task automatic wait_write(input int limit, input bit may_stall);
    bit aw_hs;
    bit w_hs;
    int cycles;
    cycles = 0;
    while ((aw_valid_i || w_valid_i) && cycles < limit) begin
      @(negedge clk_i);
      aw_hs = aw_valid_i && aw_ready_o;
      w_hs  = w_valid_i && w_ready_o;
      @(posedge clk_i);
      #1;
      if (aw_hs) aw_valid_i = 1'b0;
      if (w_hs) w_valid_i = 1'b0;
      cycles++;
    end
    stuck = aw_valid_i || w_valid_i;
    if (stuck && !may_stall) timeout_fail("write address or data handshake");
  endtask

  task automatic wait_read(input int limit, input bit may_stall);
    bit ar_hs;
    int cycles;
    cycles = 0;
    while (ar_valid_i && cycles < limit) begin
      @(negedge clk_i);
      ar_hs = ar_valid_i && ar_ready_o;
      @(posedge clk_i);
      #1;
      if (ar_hs) ar_valid_i = 1'b0;
      cycles++;
    end
    stuck = ar_valid_i;
    if (stuck && !may_stall) timeout_fail("read address handshake");
  endtask

  task automatic write_req(input addr_t a, input data_t d, input strb_t s, input id_t id,
                           input bit may_stall);
    exp_t  e;
    data_t merged;
    e.id   = id;
    e.data = '0;
    e.word = addr_word(a);
    if (e.word < `MEM_WORDS) begin
      e.resp = OKAY;
      merged = ref_mem.exists(e.word) ? ref_mem[e.word] : '0;
      for (int i = 0; i < `AXI_DATA_WIDTH / 8; i++) begin
        if (s[i]) merged[8*i +: 8] = d[8*i +: 8];
      end
      ref_mem[e.word] = merged;
    end else begin
      e.resp = SLVERR;
      e.word = -1;
    end
    exp_b.push_back(e);
    aw_valid_i = 1'b1;
    aw_id_i    = id;
    aw_addr_i  = a;
    w_valid_i  = 1'b1;
    w_data_i   = d;
    w_strb_i   = s;
    wait_write(may_stall ? STALL_LIMIT : TIMEOUT, may_stall);
  endtask

  task automatic read_req(input addr_t a, input id_t id, input bit may_stall);
    exp_t e;
    e.id   = id;
    e.word = addr_word(a);
    if (e.word < `MEM_WORDS) begin
      e.resp = OKAY;
      e.data = ref_mem[e.word];
    end else begin
      e.resp = SLVERR;
      e.data = '0;
      e.word = -1;
    end
    exp_r.push_back(e);
    ar_valid_i = 1'b1;
    ar_id_i    = id;
    ar_addr_i  = a;
    wait_read(may_stall ? STALL_LIMIT : TIMEOUT, may_stall);
  endtask

  task automatic wait_idle();
    int cycles;
    cycles = 0;
    while (exp_b.size() != 0 || exp_r.size() != 0) begin
      if (cycles == TIMEOUT) timeout_fail("outstanding B and R responses");
      @(posedge clk_i);
      #1;
      cycles++;
    end
  endtask

  // Responses are taken at the next rising edge when valid and ready
  always @(negedge clk_i) begin
    exp_t e;
    if (rst_n_i) begin
      if ((aw_valid_i && aw_ready_o) || (ar_valid_i && ar_ready_o)) req_seen = 1'b1;
      if (b_valid_o && b_ready_i) begin
        assert (exp_b.size() != 0) else report_error("B response with no write outstanding");
        e = exp_b.pop_front();
        assert (b_id_o == e.id && b_resp_o == e.resp)
          else report_error($sformatf("B id %0h resp %0d, expected id %0h resp %0d",
                                      b_id_o, b_resp_o, e.id, e.resp));
      end
      if (r_valid_o && r_ready_i) begin
        assert (exp_r.size() != 0) else report_error("R response with no read outstanding");
        e = exp_r.pop_front();
        assert (r_id_o == e.id && r_data_o == e.data && r_resp_o == e.resp)
          else report_error($sformatf("R id %0h data %h resp %0d, expected %0h %h %0d",
                                      r_id_o, r_data_o, r_resp_o, e.id, e.data, e.resp));
      end
    end
  end

  quiet_after_reset: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !req_seen |-> (!b_valid_o && !r_valid_o))
    else report_error("response valid before any request was accepted");

  b_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (b_valid_o && !b_ready_i) |=> (b_valid_o && $stable(b_id_o) && $stable(b_resp_o)))
    else report_error("B valid or payload changed before its handshake");

  r_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (r_valid_o && !r_ready_i) |=>
      (r_valid_o && $stable(r_id_o) && $stable(r_data_o) && $stable(r_resp_o)))
    else report_error("R valid or payload changed before its handshake");

  // Response readies are high three cycles in four unless held
  initial begin
    bit hold_now;
    b_ready_i = 1'b0;
    r_ready_i = 1'b0;
    forever begin
      @(posedge clk_i);
      hold_now = hold_resp;
      #1;
      stall_lfsr = lfsr_step(lfsr_step(stall_lfsr));
      b_ready_i  = !hold_now && (stall_lfsr[1:0] != 2'b00);
      stall_lfsr = lfsr_step(lfsr_step(stall_lfsr));
      r_ready_i  = !hold_now && (stall_lfsr[1:0] != 2'b00);
    end
  end

  initial begin
    rst_n_i    = 1'b0;
    aw_valid_i = 1'b0;
    aw_id_i    = '0;
    aw_addr_i  = '0;
    w_valid_i  = 1'b0;
    w_data_i   = '0;
    w_strb_i   = '0;
    ar_valid_i = 1'b0;
    ar_id_i    = '0;
    ar_addr_i  = '0;
    repeat (10) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;

    // A few idle cycles with no request in flight
    repeat (4) @(posedge clk_i);
    #1;

    // Fill pattern built from the whole byte address
    for (n = 0; n < `MEM_WORDS; n++) begin
      addr = addr_t'(n << OFFS);
      write_req(addr, {addr, ~addr}, '1, id_t'(n), 1'b0);
    end
    wait_idle();

    // Full write and a read back once B is seen
    write_req(16'h0040, 32'hDEADBEEF, 4'hF, 4'h3, 1'b0);
    wait_idle();
    read_req(16'h0040, 4'h5, 1'b0);
    wait_idle();
    // Lanes 0 and 2 only
    write_req(16'h0040, 32'h11223344, 4'b0101, 4'h6, 1'b0);
    wait_idle();
    read_req(16'h0040, 4'h7, 1'b0);
    wait_idle();
    // 16'h8040 would alias word 0x10 if the index were truncated
    write_req(16'h8040, 32'hCAFEF00D, 4'hF, 4'h9, 1'b0);
    read_req(16'h8040, 4'hA, 1'b0);
    wait_idle();
    read_req(16'h0040, 4'hB, 1'b0);
    wait_idle();

    // Hold B until the write request path backs up
    hold_resp = 1'b1;
    stuck     = 1'b0;
    for (n = 0; n < 12 && !stuck; n++) begin
      write_req(rand_addr(), rand_bits(32), '1, id_t'(rand_bits(4)), 1'b1);
    end
    assert (stuck && !aw_ready_o && !w_ready_o)
      else report_error("write request readies never dropped under B back-pressure");
    hold_resp = 1'b0;
    wait_write(TIMEOUT, 1'b0);
    wait_idle();

    // Same for reads with R held
    hold_resp = 1'b1;
    stuck     = 1'b0;
    for (n = 0; n < 12 && !stuck; n++) begin
      read_req(rand_addr(), id_t'(rand_bits(4)), 1'b1);
    end
    assert (stuck && !ar_ready_o)
      else report_error("read request ready never dropped under R back-pressure");
    hold_resp = 1'b0;
    wait_read(TIMEOUT, 1'b0);
    wait_idle();

    // Mixed traffic where a word in flight is drained before it is touched again
    for (n = 0; n < 400; n++) begin
      addr = rand_addr();
      if (addr_word(addr) < `MEM_WORDS && word_busy(addr_word(addr))) wait_idle();
      if (rand_bits(1) == 1) begin
        write_req(addr, rand_bits(32), strb_t'(rand_bits(4)), id_t'(rand_bits(4)), 1'b0);
      end else begin
        read_req(addr, id_t'(rand_bits(4)), 1'b0);
      end
    end
    wait_idle();

    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: rtl/axi_mem_sys.sv
// ==========================================================================
// AXI memory subsystem top level
// Plain AXI ports are bundled, buffered per channel and served from memory
// ==========================================================================
`timescale 1ns/100ps
`default_nettype none

`include "axi_defines.svh"

module axi_mem_sys (
  input  logic            clk_i,
  input  logic            rst_n_i,
  // Write address
  input  logic            aw_valid_i,
  output logic            aw_ready_o,
  input  axi_pkg::id_t    aw_id_i,
  input  axi_pkg::addr_t  aw_addr_i,
  // Write data
  input  logic            w_valid_i,
  output logic            w_ready_o,
  input  axi_pkg::data_t  w_data_i,
  input  axi_pkg::strb_t  w_strb_i,
  // Write response
  output logic            b_valid_o,
  input  logic            b_ready_i,
  output axi_pkg::id_t    b_id_o,
  output axi_pkg::resp_e  b_resp_o,
  // Read address
  input  logic            ar_valid_i,
  output logic            ar_ready_o,
  input  axi_pkg::id_t    ar_id_i,
  input  axi_pkg::addr_t  ar_addr_i,
  // Read data
  output logic            r_valid_o,
  input  logic            r_ready_i,
  output axi_pkg::id_t    r_id_o,
  output axi_pkg::data_t  r_data_o,
  output axi_pkg::resp_e  r_resp_o
);

  axi_bus_if up_bus ();
  axi_bus_if mem_bus ();

  // Manager side of up_bus comes from the ports
  assign up_bus.aw_valid = aw_valid_i;
  assign up_bus.aw       = '{id: aw_id_i, addr: aw_addr_i};
  assign up_bus.w_valid  = w_valid_i;
  assign up_bus.w        = '{data: w_data_i, strb: w_strb_i};
  assign up_bus.ar_valid = ar_valid_i;
  assign up_bus.ar       = '{id: ar_id_i, addr: ar_addr_i};
  assign up_bus.b_ready  = b_ready_i;
  assign up_bus.r_ready  = r_ready_i;

  assign aw_ready_o = up_bus.aw_ready;
  assign w_ready_o  = up_bus.w_ready;
  assign ar_ready_o = up_bus.ar_ready;
  assign b_valid_o  = up_bus.b_valid;
  assign b_id_o     = up_bus.b.id;
  assign b_resp_o   = up_bus.b.resp;
  assign r_valid_o  = up_bus.r_valid;
  assign r_id_o     = up_bus.r.id;
  assign r_data_o   = up_bus.r.data;
  assign r_resp_o   = up_bus.r.resp;

  axi_fifo #(
    .DEPTH        (`AXI_FIFO_DEPTH),
    .FALL_THROUGH (`AXI_FIFO_FALL_THROUGH)
  ) i_axi_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .sbr     (up_bus.sbr),
    .mgr     (mem_bus.mgr)
  );

  axi_mem_sbr #(
    .WORDS (`MEM_WORDS)
  ) i_axi_mem_sbr (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .bus     (mem_bus.sbr)
  );

endmodule

`default_nettype wire

// File: rtl/axi_mem_sbr.sv
// ==========================================================================
// AXI memory subordinate
// Single-beat word memory with byte strobes and an address range check.
// B and R responses come from one-entry registers, valid the next cycle
// ==========================================================================
`timescale 1ns/100ps
`default_nettype none

`include "axi_defines.svh"

module axi_mem_sbr #(
  parameter int unsigned WORDS = `MEM_WORDS
) (
  input  logic clk_i,
  input  logic rst_n_i,
  axi_bus_if.sbr bus
);

  import axi_pkg::*;
  import mem_pkg::*;

  localparam int unsigned ADDR_W      = $bits(addr_t);
  localparam int unsigned WORD_ADDR_W = ADDR_W - BYTE_OFFSET_W;
  localparam int unsigned IDX_W       = $bits(word_idx_t);

  mem_word_t              mem_q [WORDS];
  logic [WORD_ADDR_W-1:0] aw_word;
  logic [WORD_ADDR_W-1:0] ar_word;
  word_idx_t              aw_idx;
  word_idx_t              ar_idx;
  logic                   aw_in_range;
  logic                   ar_in_range;
  logic                   b_free;
  logic                   r_free;
  logic                   wr_fire;
  logic                   rd_fire;
  logic                   b_valid_q;
  logic                   r_valid_q;
  b_chan_t                b_q;
  r_chan_t                r_q;

  // Drop the byte offset, then check against the array size
  assign aw_word     = bus.aw.addr[ADDR_W-1:BYTE_OFFSET_W];
  assign ar_word     = bus.ar.addr[ADDR_W-1:BYTE_OFFSET_W];
  assign aw_in_range = (aw_word < WORD_ADDR_W'(WORDS));
  assign ar_in_range = (ar_word < WORD_ADDR_W'(WORDS));
  assign aw_idx      = aw_word[IDX_W-1:0];
  assign ar_idx      = ar_word[IDX_W-1:0];

  // Register is free if empty or drained this cycle
  assign b_free = ~b_valid_q | bus.b_ready;
  assign r_free = ~r_valid_q | bus.r_ready;

  // Address and data are taken as a pair
  assign wr_fire      = bus.aw_valid & bus.w_valid & b_free;
  assign bus.aw_ready = bus.w_valid & b_free;
  assign bus.w_ready  = bus.aw_valid & b_free;

  assign rd_fire      = bus.ar_valid & r_free;
  assign bus.ar_ready = r_free;

  assign bus.b_valid = b_valid_q;
  assign bus.b       = b_q;
  assign bus.r_valid = r_valid_q;
  assign bus.r       = r_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      b_valid_q <= 1'b0;
      r_valid_q <= 1'b0;
    end else begin
      if (wr_fire) begin
        b_valid_q <= 1'b1;
      end else if (bus.b_ready) begin
        b_valid_q <= 1'b0;
      end
      if (rd_fire) begin
        r_valid_q <= 1'b1;
      end else if (bus.r_ready) begin
        r_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_fire) begin
      b_q.id   <= bus.aw.id;
      b_q.resp <= aw_in_range ? OKAY : SLVERR;
      if (aw_in_range) begin
        // Merge only the enabled byte lanes
        for (int i = 0; i < LANES; i++) begin
          if (bus.w.strb[i]) begin
            mem_q[aw_idx][8*i +: 8] <= bus.w.data[8*i +: 8];
          end
        end
      end
    end
    if (rd_fire) begin
      r_q.id   <= bus.ar.id;
      r_q.data <= ar_in_range ? mem_q[ar_idx] : '0;
      r_q.resp <= ar_in_range ? OKAY : SLVERR;
    end
  end

endmodule

`default_nettype wire

// File: rtl/axi_fifo.sv
// ==========================================================================
// AXI channel FIFO
// Buffers aw, w and ar downstream and b and r upstream, one fifo_v3 per
// channel, cutting all combinational paths between the two sides
// ==========================================================================
`timescale 1ns/100ps
`default_nettype none

module axi_fifo #(
  parameter int unsigned DEPTH        = 1,
  parameter bit          FALL_THROUGH = 1'b0
) (
  input  logic clk_i,
  input  logic rst_n_i,
  axi_bus_if.sbr sbr,
  axi_bus_if.mgr mgr
);

  import axi_pkg::*;

  logic aw_full, w_full, ar_full, b_full, r_full;
  logic aw_empty, w_empty, ar_empty, b_empty, r_empty;

  // Input side accepts while there is room
  assign sbr.aw_ready = ~aw_full;
  assign sbr.w_ready  = ~w_full;
  assign sbr.ar_ready = ~ar_full;
  assign mgr.b_ready  = ~b_full;
  assign mgr.r_ready  = ~r_full;

  // Output side presents whatever is stored
  assign mgr.aw_valid = ~aw_empty;
  assign mgr.w_valid  = ~w_empty;
  assign mgr.ar_valid = ~ar_empty;
  assign sbr.b_valid  = ~b_empty;
  assign sbr.r_valid  = ~r_empty;

  fifo_v3 #(.DEPTH(DEPTH), .FALL_THROUGH(FALL_THROUGH), .dtype(aw_chan_t)) i_aw_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (sbr.aw_valid & sbr.aw_ready),
    .data_i  (sbr.aw),
    .pop_i   (mgr.aw_valid & mgr.aw_ready),
    .data_o  (mgr.aw),
    .full_o  (aw_full),
    .empty_o (aw_empty)
  );

  fifo_v3 #(.DEPTH(DEPTH), .FALL_THROUGH(FALL_THROUGH), .dtype(w_chan_t)) i_w_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (sbr.w_valid & sbr.w_ready),
    .data_i  (sbr.w),
    .pop_i   (mgr.w_valid & mgr.w_ready),
    .data_o  (mgr.w),
    .full_o  (w_full),
    .empty_o (w_empty)
  );

  fifo_v3 #(.DEPTH(DEPTH), .FALL_THROUGH(FALL_THROUGH), .dtype(ar_chan_t)) i_ar_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (sbr.ar_valid & sbr.ar_ready),
    .data_i  (sbr.ar),
    .pop_i   (mgr.ar_valid & mgr.ar_ready),
    .data_o  (mgr.ar),
    .full_o  (ar_full),
    .empty_o (ar_empty)
  );

  // Response channels run the other way
  fifo_v3 #(.DEPTH(DEPTH), .FALL_THROUGH(FALL_THROUGH), .dtype(b_chan_t)) i_b_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (mgr.b_valid & mgr.b_ready),
    .data_i  (mgr.b),
    .pop_i   (sbr.b_valid & sbr.b_ready),
    .data_o  (sbr.b),
    .full_o  (b_full),
    .empty_o (b_empty)
  );

  fifo_v3 #(.DEPTH(DEPTH), .FALL_THROUGH(FALL_THROUGH), .dtype(r_chan_t)) i_r_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (mgr.r_valid & mgr.r_ready),
    .data_i  (mgr.r),
    .pop_i   (sbr.r_valid & sbr.r_ready),
    .data_o  (sbr.r),
    .full_o  (r_full),
    .empty_o (r_empty)
  );

endmodule

`default_nettype wire

// File: rtl/fifo_v3.sv
// ==========================================================================
// Generic typed FIFO
// Circular buffer with occupancy counter, full and empty flags, and an
// optional fall-through mode for a zero-latency path when empty
// ==========================================================================
`timescale 1ns/100ps
`default_nettype none

module fifo_v3 #(
  parameter int unsigned DEPTH        = 2,
  parameter bit          FALL_THROUGH = 1'b0,
  parameter type         dtype        = logic
) (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic push_i,
  input  dtype data_i,
  input  logic pop_i,
  output dtype data_o,
  output logic full_o,
  output logic empty_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  dtype             mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             is_empty;
  logic             bypass;
  logic             do_push;
  logic             do_pop;

  assign is_empty = (count_q == '0);
  assign full_o   = (count_q == CNT_W'(DEPTH));

  // In fall-through mode a push into an empty FIFO is visible at once
  assign empty_o  = is_empty & ~(FALL_THROUGH & push_i);
  assign data_o   = (FALL_THROUGH && is_empty) ? data_i : mem_q[rd_ptr_q];

  // Item passes straight through, storage untouched
  assign bypass  = FALL_THROUGH & is_empty & push_i & pop_i;
  assign do_push = push_i & ~full_o & ~bypass;
  assign do_pop  = pop_i & ~empty_o & ~bypass;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        if (wr_ptr_q == PTR_W'(DEPTH - 1)) begin
          wr_ptr_q <= '0;
        end else begin
          wr_ptr_q <= wr_ptr_q + 1'b1;
        end
      end
      if (do_pop) begin
        if (rd_ptr_q == PTR_W'(DEPTH - 1)) begin
          rd_ptr_q <= '0;
        end else begin
          rd_ptr_q <= rd_ptr_q + 1'b1;
        end
      end
      count_q <= count_q + CNT_W'(do_push) - CNT_W'(do_pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

`default_nettype wire

// File: rtl/axi_bus_if.sv
// ==========================================================================
// AXI channel bundle
// Five valid/ready channels with manager and subordinate views
// ==========================================================================
`timescale 1ns/100ps
`default_nettype none

interface axi_bus_if;

  import axi_pkg::*;

  // Request channels
  logic     aw_valid;
  logic     aw_ready;
  aw_chan_t aw;

  logic     w_valid;
  logic     w_ready;
  w_chan_t  w;

  logic     ar_valid;
  logic     ar_ready;
  ar_chan_t ar;

  // Response channels
  logic     b_valid;
  logic     b_ready;
  b_chan_t  b;

  logic     r_valid;
  logic     r_ready;
  r_chan_t  r;

  modport mgr (
    output aw_valid, aw, w_valid, w, ar_valid, ar, b_ready, r_ready,
    input  aw_ready, w_ready, ar_ready, b_valid, b, r_valid, r
  );

  modport sbr (
    input  aw_valid, aw, w_valid, w, ar_valid, ar, b_ready, r_ready,
    output aw_ready, w_ready, ar_ready, b_valid, b, r_valid, r
  );

endinterface

`default_nettype wire

// File: rtl/mem_pkg.sv
// ==========================================================================
// Memory-side types
// Word indexing and storage word layout of the AXI memory subordinate
// ==========================================================================
`default_nettype none

`include "axi_defines.svh"

package mem_pkg;

  // Byte lanes per storage word
  localparam int unsigned LANES = `AXI_DATA_WIDTH / 8;
  localparam int unsigned BYTE_OFFSET_W = $clog2(LANES);

  typedef logic [$clog2(`MEM_WORDS)-1:0] word_idx_t;
  typedef logic [`AXI_DATA_WIDTH-1:0] mem_word_t;

endpackage

`default_nettype wire

// File: rtl/axi_pkg.sv
// ==========================================================================
// AXI channel types
// Single-beat channel payloads and response codes for the AXI subsystem
// ==========================================================================
`default_nettype none

`include "axi_defines.svh"

package axi_pkg;

  typedef logic [`AXI_ADDR_WIDTH-1:0] addr_t;
  typedef logic [`AXI_DATA_WIDTH-1:0] data_t;
  typedef logic [`AXI_DATA_WIDTH/8-1:0] strb_t;
  typedef logic [`AXI_ID_WIDTH-1:0] id_t;

  // EXOKAY and DECERR are never produced here
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } resp_e;

  typedef struct packed {
    id_t   id;
    addr_t addr;
  } aw_chan_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
  } w_chan_t;

  typedef struct packed {
    id_t   id;
    resp_e resp;
  } b_chan_t;

  typedef struct packed {
    id_t   id;
    addr_t addr;
  } ar_chan_t;

  typedef struct packed {
    id_t   id;
    data_t data;
    resp_e resp;
  } r_chan_t;

endpackage

`default_nettype wire

// File: rtl/axi_defines.svh
// ==========================================================================
// AXI memory subsystem build parameters
// Bus widths, channel FIFO configuration and memory size
// ==========================================================================
`ifndef AXI_DEFINES_SVH
`define AXI_DEFINES_SVH

// Bus widths in bits
`define AXI_ADDR_WIDTH 16
`define AXI_DATA_WIDTH 32
`define AXI_ID_WIDTH 4

// Channel buffering
`define AXI_FIFO_DEPTH 2
`define AXI_FIFO_FALL_THROUGH 1'b0

`define MEM_WORDS 256

`endif
